// File: filelist.f
+incdir+dv
rtl/wrra_pkg.sv
rtl/contention_accum.sv
rtl/weight_counter_bank.sv
rtl/rr_priority_ctrl.sv
rtl/wrra_top.sv
dv/wrra_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := wrra_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard dv/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/wrra_model.svh
`ifndef WRRA_MODEL_SVH
`define WRRA_MODEL_SVH

weight_array_t cnt_m;                                    // burst counters of the model
int            prio_m;                                   // index of the highest priority input
int            winner_m;                                 // -1 when nobody wins

// expected outputs for the inputs of the current cycle
arb_vec_t      exp_grant;
logic          exp_any;
logic          exp_consumed;
contention_t   exp_cont;

function automatic weight_t eff_weight(weight_t w);
    return (w == '0) ? weight_t'(1) : w;                 // zero is served as one
endfunction

task automatic reset_model();
    cnt_m  = '0;
    prio_m = 0;
endtask

task automatic eval_outputs(arb_req_t r);
    int idx;
    exp_grant    = '0;
    exp_consumed = 1'b0;
    exp_cont     = '0;
    winner_m     = -1;
    for (int k = 0; k < ARB_N; k++) begin
        idx = (prio_m + k) % ARB_N;                      // scan from the priority, wrapping
        if (winner_m < 0 && r.request[idx]) begin
            winner_m = idx;
        end
    end
    exp_any = (winner_m >= 0);
    if (exp_any) begin
        exp_grant[winner_m] = 1'b1;
        exp_consumed        = (cnt_m[winner_m] == '0);
    end
    for (int i = 0; i < ARB_N; i++) begin
        if (r.request[i]) begin
            exp_cont = exp_cont + contention_t'(r.weights[i]);  // raw weight
        end
    end
endtask

// uses the expected outputs of the same cycle, so call eval_outputs first
task automatic advance_state(arb_req_t r, logic pr_en);
    for (int i = 0; i < ARB_N; i++) begin
        if (exp_grant[i] && cnt_m[i] == '0) begin
            cnt_m[i] = eff_weight(r.weights[i]) - weight_t'(1);
        end else if (exp_grant[i]) begin
            cnt_m[i] = cnt_m[i] - weight_t'(1);
        end else if (cnt_m[i] > r.weights[i]) begin
            cnt_m[i] = eff_weight(r.weights[i]) - weight_t'(1);  // weight dropped
        end
    end
    if (exp_any && pr_en && exp_consumed) begin
        prio_m = (winner_m + 1) % ARB_N;
    end
endtask

`endif

// File: dv/wrra_tb.sv
module wrra_tb
    import wrra_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        counter_is_reset;
    arb_req_t    req;
    logic        ext_pr_en;
    arb_result_t result;
    contention_t contention;

    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    string       test_name;
    arb_vec_t    got_grant;                              // DUT outputs of the last cycle
    logic        got_consumed;

    `include "wrra_model.svh"

    wrra_top UUT (
        .clk              (clk),
        .counter_is_reset (counter_is_reset),
        .req_i            (req),
        .ext_pr_en_i      (ext_pr_en),
        .result_o         (result),
        .contention_o     (contention)
    );

    always #50 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic arb_vec_t one_hot(int i);
        arb_vec_t v;
        v    = '0;
        v[i] = 1'b1;
        return v;
    endfunction

    function automatic weight_array_t make_weights(int w0, int w1, int w2, int w3);
        weight_array_t w;
        w[0] = weight_t'(w0);
        w[1] = weight_t'(w1);
        w[2] = weight_t'(w2);
        w[3] = weight_t'(w3);
        return w;
    endfunction

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_grant(string what, arb_vec_t exp, arb_vec_t act);
        checks++;
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act);
            count_error();
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act);
            count_error();
        end
    endtask

    task automatic check_contention(string what, contention_t exp, contention_t act);
        checks++;
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            count_error();
        end
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%s finished with %0d errors", test_name, test_errors);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #5;
        counter_is_reset = 1'b1;
        req              = '0;
        ext_pr_en        = 1'b1;
        repeat (16) @(posedge clk);
        #5;
        counter_is_reset = 1'b0;
        reset_model();
    endtask

    // drive after the edge, check just before the next one, then step the model
    task automatic run_cycle(arb_req_t r, logic en);
        @(posedge clk);
        #5;
        req       = r;
        ext_pr_en = en;
        eval_outputs(r);
        #90;
        check_grant("grant", exp_grant, result.grant);
        check_flag("any_grant", exp_any, result.any_grant);
        check_flag("winner_consumed", exp_consumed, result.winner_consumed);
        check_contention("contention", exp_cont, contention);
        got_grant    = result.grant;
        got_consumed = result.winner_consumed;
        advance_state(r, en);
    endtask

    initial begin
        #2_000_000;
        $display("timeout: the test sequence did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        arb_req_t r;
        arb_vec_t exp_q[$];
        logic     cons_q[$];
        int       tmo;
        int       burst;
        int       e;
        logic     found;
        logic     done;

        clk              = 1'b0;
        counter_is_reset = 1'b1;
        req              = '0;
        ext_pr_en        = 1'b0;
        lfsr             = 32'h9af4;
        checks           = 0;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;

        start_test("reset_idle");
        apply_reset();
        r.request = '0;
        r.weights = make_weights(1, 1, 1, 1);
        run_cycle(r, 1'b1);
        check_grant("idle grant", '0, got_grant);
        r.request = '1;
        run_cycle(r, 1'b1);
        check_grant("first grant", one_hot(0), got_grant);
        end_test();

        start_test("weighted_bursts");
        apply_reset();
        r.request = '1;
        r.weights = make_weights(3, 0, 2, 4);
        for (int i = 0; i < ARB_N; i++) begin                // counters start at zero
            exp_q.push_back(one_hot(i));
            cons_q.push_back(1'b1);
        end
        for (int n = 0; n < 2; n++) begin
            for (int i = 0; i < ARB_N; i++) begin
                e = int'(eff_weight(r.weights[i]));
                for (int k = 0; k < e; k++) begin
                    exp_q.push_back(one_hot(i));
                    cons_q.push_back(k == e - 1);            // last grant of the burst
                end
            end
        end
        for (int k = 0; k < exp_q.size(); k++) begin
            run_cycle(r, 1'b1);
            check_grant("burst order", exp_q[k], got_grant);
            check_flag("burst end", cons_q[k], got_consumed);
        end
        end_test();

        start_test("priority_hold");
        apply_reset();
        r.request = '1;
        r.weights = make_weights(3, 2, 1, 2);
        for (int c = 0; c < 12; c++) begin
            run_cycle(r, 1'b0);
            check_grant("held grant", one_hot(0), got_grant);
            check_flag("counter wrap", (c % 3) == 0, got_consumed);
        end
        end_test();

        start_test("weight_drop");
        apply_reset();
        r.request = '1;
        r.weights = make_weights(1, 1, 5, 1);
        found     = 1'b0;
        tmo       = 0;
        while (!found && tmo < 40) begin                     // wait for input 2 mid burst
            run_cycle(r, 1'b1);
            found = (got_grant == one_hot(2)) && !got_consumed;
            tmo++;
        end
        if (!found) begin
            $display("%s: input 2 never reached the middle of a burst", test_name);
            count_error();
        end
        r.request    = 4'b1011;                              // input 2 steps out once
        r.weights[2] = weight_t'(2);
        run_cycle(r, 1'b0);
        r.request = '1;
        burst     = 0;
        done      = 1'b0;
        tmo       = 0;
        while (!done && tmo < 20) begin
            run_cycle(r, 1'b1);
            if (got_grant == one_hot(2)) begin
                burst++;
            end else begin
                done = 1'b1;
            end
            tmo++;
        end
        if (!done) begin
            $display("%s: input 2 kept the grant past the end of its burst", test_name);
            count_error();
        end else if (burst != 2) begin
            $display("[FAIL] %s burst length: expected 2, actual %0d", test_name, burst);
            count_error();
        end
        end_test();

        start_test("random_traffic");
        apply_reset();
        for (int c = 0; c < 2000; c++) begin
            r.request = arb_vec_t'(random_bits(ARB_N));
            for (int i = 0; i < ARB_N; i++) begin
                r.weights[i] = weight_t'(random_bits(WEIGHTw));
            end
            run_cycle(r, lfsr_bit());
        end
        end_test();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: rtl/wrra_top.sv
module wrra_top
    import wrra_pkg::*;
(
    input  logic        clk,
    input  logic        counter_is_reset,
    input  arb_req_t    req_i,
    input  logic        ext_pr_en_i,
    output arb_result_t result_o,
    output contention_t contention_o
);

    arb_vec_t grant;
    logic     any_grant;
    logic     winner_consumed;                           // closes the loop back into the ctrl

    // rotating priority, locked on the winner until its burst is used up
    rr_priority_ctrl u_ctrl (
        .clk               (clk),
        .counter_is_reset  (counter_is_reset),
        .request_i         (req_i.request),
        .ext_pr_en_i       (ext_pr_en_i),
        .winner_consumed_i (winner_consumed),
        .grant_o           (grant),
        .any_grant_o       (any_grant)
    );

    weight_counter_bank u_bank (
        .clk               (clk),
        .counter_is_reset  (counter_is_reset),
        .weights_i         (req_i.weights),
        .grant_i           (grant),
        .winner_consumed_o (winner_consumed)
    );

    contention_accum u_cont (
        .req_i        (req_i),
        .contention_o (contention_o)
    );

    assign result_o = '{
        grant:           grant,
        any_grant:       any_grant,
        winner_consumed: winner_consumed
    };

endmodule

// File: rtl/rr_priority_ctrl.sv
module rr_priority_ctrl
    import wrra_pkg::*;
(
    input  logic     clk,
    input  logic     counter_is_reset,
    input  arb_vec_t request_i,
    input  logic     ext_pr_en_i,
    input  logic     winner_consumed_i,
    output arb_vec_t grant_o,
    output logic     any_grant_o
);

    arb_vec_t             prio_q;                        // one-hot, highest priority input
    arb_vec_t             prio_d;
    arb_vec_t             prio_next;                     // input just after the winner
    logic [2*ARB_N-1:0]   req_dbl;                       // request twice for the wrap
    logic [2*ARB_N-1:0]   gnt_dbl;
    logic                 rotate;

    assign req_dbl = {request_i, request_i};

    // subtracting the one-hot priority borrows up to the first request at or
    // above it, which is the only bit that survives the mask
    assign gnt_dbl = req_dbl & ~(req_dbl - {{ARB_N{1'b0}}, prio_q});

    assign grant_o     = gnt_dbl[ARB_N-1:0] | gnt_dbl[2*ARB_N-1:ARB_N];  // fold upper copy
    assign any_grant_o = |request_i;

    // priority moves only once the winner has spent its weight
    assign rotate    = any_grant_o & ext_pr_en_i & winner_consumed_i;
    assign prio_next = {grant_o[ARB_N-2:0], grant_o[ARB_N-1]};
    assign prio_d    = rotate ? prio_next : prio_q;

    always_ff @(posedge clk) begin
        if (counter_is_reset) begin
            prio_q <= arb_vec_t'(1);                     // input 0 first
        end else begin
            prio_q <= prio_d;
        end
    end

    // at most one winner, and only among the inputs that ask
    a_grant_onehot0: assert property (
        @(posedge clk) disable iff (counter_is_reset)
        $onehot0(grant_o) && ((grant_o & ~request_i) == '0)
    );

    // a request always produces a winner in the same cycle
    a_any_grant: assert property (
        @(posedge clk) disable iff (counter_is_reset)
        any_grant_o == |grant_o
    );

    a_prio_onehot: assert property (
        @(posedge clk) disable iff (counter_is_reset)
        $onehot(prio_q)
    );

endmodule

// File: rtl/weight_counter_bank.sv
module weight_counter_bank
    import wrra_pkg::*;
(
    input  logic          clk,
    input  logic          counter_is_reset,
    input  weight_array_t weights_i,
    input  arb_vec_t      grant_i,
    output logic          winner_consumed_o
);

    weight_array_t cnt_q;                                // grants left in the burst, minus one
    weight_array_t cnt_d;
    weight_array_t eff_w;                                // zero weight raised to one
    arb_vec_t      cnt_zero;
    arb_vec_t      over_w;                               // weight dropped below the counter
    arb_vec_t      reload;

    always_comb begin
        for (int i = 0; i < ARB_N; i++) begin
            eff_w[i]    = (weights_i[i] == '0) ? weight_t'(1) : weights_i[i];
            cnt_zero[i] = (cnt_q[i] == '0);
            over_w[i]   = (cnt_q[i] > weights_i[i]);

            // a granted input only reloads at the end of its burst
            reload[i] = grant_i[i] ? cnt_zero[i] : over_w[i];

            if (reload[i]) begin
                cnt_d[i] = eff_w[i] - 1'b1;
            end else if (grant_i[i]) begin
                cnt_d[i] = cnt_q[i] - 1'b1;              // one grant of the burst used
            end else begin
                cnt_d[i] = cnt_q[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (counter_is_reset) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // one-hot mux of the zero flags, low when nobody wins
    assign winner_consumed_o = |(grant_i & cnt_zero);

endmodule

// File: rtl/contention_accum.sv
module contention_accum
    import wrra_pkg::*;
(
    input  arb_req_t    req_i,
    output contention_t contention_o
);

    weight_array_t masked_w;                             // zero where the input is idle
    contention_t   sum;

    // raw weights are summed here, a zero weight adds nothing to the
    // contention even though the arbiter serves it as one
    always_comb begin
        sum = '0;
        for (int i = 0; i < ARB_N; i++) begin
            masked_w[i] = req_i.request[i] ? req_i.weights[i] : weight_t'(0);
            sum         = sum + contention_t'(masked_w[i]);  // widen before the add
        end
    end

    assign contention_o = sum;

endmodule

// File: rtl/wrra_pkg.sv
package wrra_pkg;

    localparam int ARB_N   = 4;                          // inputs sharing one output port
    localparam int WEIGHTw = 4;                          // bits per weight
    localparam int CONTw   = WEIGHTw + $clog2(ARB_N);    // room for ARB_N full weights

    // one bit per input: request, grant, priority
    typedef logic [ARB_N-1:0] arb_vec_t;

    typedef logic [WEIGHTw-1:0] weight_t;

    // index i holds the weight of input i
    typedef weight_t [ARB_N-1:0] weight_array_t;

    typedef logic [CONTw-1:0] contention_t;

    // what the input ports present to the output arbiter each cycle
    typedef struct packed {
        arb_vec_t      request;                          // level, held while waiting
        weight_array_t weights;                          // zero is served as one
    } arb_req_t;

    // same-cycle arbitration outcome
    typedef struct packed {
        arb_vec_t grant;                                 // one-hot or zero
        logic     any_grant;
        logic     winner_consumed;                       // last grant of the burst
    } arb_result_t;

endpackage
